// ==== bench/video_regs_assert.sv ====
`timescale 1ns/1ps

module video_regs_assert (
  input logic                     clk,
  input logic                     rst,
  input logic                     mpu_en,
  input logic                     mpu_rd,
  input video_map_pkg::mpu_data_t mpu_data_out,
  input logic                     vram_en,
  input logic                     vram_rd,
  input logic                     vram_wr
);

  // Read data only follows a read strobe
  property data_zero_after_no_read;
    @(posedge clk) disable iff (rst) !(mpu_en && mpu_rd) |=> (mpu_data_out == '0);
  endproperty

  data_zero_a: assert property (data_zero_after_no_read)
    else $error("mpu_data_out is not zero after a cycle without a read");

  vram_rd_wr_a: assert property (@(posedge clk) disable iff (rst) !(vram_rd && vram_wr))
    else $error("vram_rd and vram_wr are high together");

  vram_strobe_en_a: assert property (@(posedge clk) disable iff (rst)
      (vram_rd || vram_wr) |-> vram_en)
    else $error("video RAM strobe is high without vram_en");

endmodule

// Watches the read mux output and the video RAM port at the top level
bind video_regs_top video_regs_assert assert_i (
  .clk          (clk),
  .rst          (rst),
  .mpu_en       (mpu_en),
  .mpu_rd       (mpu_rd),
  .mpu_data_out (mpu_data_out),
  .vram_en      (vram_en),
  .vram_rd      (vram_rd),
  .vram_wr      (vram_wr)
);

// ==== bench/video_regs_tb.sv ====
`timescale 1ns/1ps

module video_regs_tb;

  localparam int NUM_MAIN_REGS   = 8;
  localparam int NUM_TILE_LAYERS = 4;
  localparam int NUM_TILE_REGS   = 8;
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_RANDOM      = 48;

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_WR   = 2'd2;

  typedef struct packed {
    logic [1:0]                op;
    video_map_pkg::mpu_addr_t  addr;
    video_map_pkg::mpu_data_t  data;
    logic [1:0]                be;
    video_map_pkg::mpu_data_t  vdin;
  } step_t;

  logic                      clk;
  logic                      rst;
  logic                      mpu_en;
  logic                      mpu_rd;
  logic                      mpu_wr;
  logic [1:0]                mpu_be;
  video_map_pkg::mpu_addr_t  mpu_addr;
  video_map_pkg::mpu_data_t  mpu_data_in;
  video_map_pkg::mpu_data_t  vram_data_in;
  video_map_pkg::mpu_data_t  mpu_data_out;
  logic                      vram_en;
  logic                      vram_rd;
  logic                      vram_wr;
  logic [1:0]                vram_be;
  video_map_pkg::vram_addr_t vram_addr;
  video_map_pkg::mpu_data_t  vram_data_out;

  step_t  table_q [$];
  logic   table_ready = 1'b0;
  integer seed = 32'h05a1fae2;
  int     cur_step = -1;

  // Reference register contents
  video_regs_pkg::reg_data_t main_m [NUM_MAIN_REGS];
  video_regs_pkg::reg_data_t tile_m [NUM_TILE_LAYERS][NUM_TILE_REGS];

  // Expected outputs one cycle after the last applied step
  video_map_pkg::mpu_data_t  exp_rdata;
  video_map_pkg::mpu_data_t  exp_vdata;
  logic                      exp_en;
  logic                      exp_rd;
  logic                      exp_wr;
  logic [1:0]                exp_be;
  video_map_pkg::vram_addr_t exp_addr;

  video_regs_top #(
    .NUM_MAIN_REGS   (NUM_MAIN_REGS),
    .NUM_TILE_LAYERS (NUM_TILE_LAYERS),
    .NUM_TILE_REGS   (NUM_TILE_REGS)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .mpu_en        (mpu_en),
    .mpu_rd        (mpu_rd),
    .mpu_wr        (mpu_wr),
    .mpu_be        (mpu_be),
    .mpu_addr      (mpu_addr),
    .mpu_data_in   (mpu_data_in),
    .vram_data_in  (vram_data_in),
    .mpu_data_out  (mpu_data_out),
    .vram_en       (vram_en),
    .vram_rd       (vram_rd),
    .vram_wr       (vram_wr),
    .vram_be       (vram_be),
    .vram_addr     (vram_addr),
    .vram_data_out (vram_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(input string name, input video_map_pkg::mpu_data_t got,
                            input video_map_pkg::mpu_data_t exp);
    if (got !== exp) begin
      $display("FAILED %s after step %0d: got 0x%h, expected 0x%h", name, cur_step, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input video_map_pkg::vram_addr_t got,
                            input video_map_pkg::vram_addr_t exp);
    if (got !== exp) begin
      $display("FAILED %s after step %0d: got 0x%h, expected 0x%h", name, cur_step, got, exp);
      stop_run();
    end
  endtask

  task automatic check_strobe(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s after step %0d: got 0x%h, expected 0x%h", name, cur_step, got, exp);
      stop_run();
    end
  endtask

  task automatic check_be(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s after step %0d: got 0x%h, expected 0x%h", name, cur_step, got, exp);
      stop_run();
    end
  endtask

  task automatic check_outputs();
    check_data("mpu_data_out", mpu_data_out, exp_rdata);
    check_strobe("vram_en", vram_en, exp_en);
    check_strobe("vram_rd", vram_rd, exp_rd);
    check_strobe("vram_wr", vram_wr, exp_wr);
    check_be("vram_be", vram_be, exp_be);
    check_addr("vram_addr", vram_addr, exp_addr);
    check_data("vram_data_out", vram_data_out, exp_vdata);
  endtask

  // Page 1 takes the bank register as its upper bits
  function automatic video_map_pkg::int_addr_t bank_addr(input video_map_pkg::mpu_addr_t a);
    video_regs_pkg::bank_t bank;
    bank = a[15] ? main_m[video_regs_pkg::REG_MEM_BANK][7:0] : 8'h00;
    return {bank, a[14:0]};
  endfunction

  function automatic logic in_window(input video_map_pkg::int_addr_t ia);
    return (ia >= video_map_pkg::VRAM_BASE) &&
           (ia < video_map_pkg::VRAM_BASE + video_map_pkg::VRAM_LENGTH);
  endfunction

  function automatic logic vram_open();
    return main_m[video_regs_pkg::REG_SYS_CTRL][video_regs_pkg::SYS_CTRL_VRAM_ACCESS];
  endfunction

  function automatic logic tile_hit(input video_map_pkg::int_addr_t ia);
    video_map_pkg::int_addr_t rel;
    rel = ia - video_map_pkg::TILE_REG_BASE;
    return (ia >= video_map_pkg::TILE_REG_BASE) &&
           (rel < video_map_pkg::TILE_REG_STEP * 23'(NUM_TILE_LAYERS)) &&
           (rel[3:0] < 4'(NUM_TILE_REGS));
  endfunction

  function automatic video_map_pkg::mpu_data_t expected_read(
      input video_map_pkg::int_addr_t ia, input video_map_pkg::mpu_data_t vdin);
    video_map_pkg::int_addr_t rel;
    rel = ia - video_map_pkg::TILE_REG_BASE;
    if (ia < video_map_pkg::LOW_MEM_SIZE) begin
      if (ia < 23'(NUM_MAIN_REGS)) begin
        if (ia[2:0] == 3'(video_regs_pkg::REG_ID)) begin
          return video_regs_pkg::ID_VALUE;
        end
        return main_m[ia[2:0]];
      end
      if (tile_hit(ia)) begin
        return tile_m[rel[5:4]][rel[2:0]];
      end
      return video_map_pkg::UNMAPPED_VALUE;
    end
    if (in_window(ia) && vram_open()) begin
      return vdin;
    end
    return video_map_pkg::UNMAPPED_VALUE;
  endfunction

  function automatic video_regs_pkg::reg_data_t merge_bytes(
      input video_regs_pkg::reg_data_t old, input video_map_pkg::mpu_data_t data,
      input logic [1:0] be);
    return {be[1] ? data[15:8] : old[15:8], be[0] ? data[7:0] : old[7:0]};
  endfunction

  function automatic void model_write(input video_map_pkg::int_addr_t ia,
                                      input video_map_pkg::mpu_data_t data, input logic [1:0] be);
    video_map_pkg::int_addr_t rel;
    rel = ia - video_map_pkg::TILE_REG_BASE;
    if (ia < 23'(NUM_MAIN_REGS)) begin
      // ID stays fixed
      if (ia[2:0] != 3'(video_regs_pkg::REG_ID)) begin
        main_m[ia[2:0]] = merge_bytes(main_m[ia[2:0]], data, be);
      end
    end else if (tile_hit(ia)) begin
      tile_m[rel[5:4]][rel[2:0]] = merge_bytes(tile_m[rel[5:4]][rel[2:0]], data, be);
    end
  endfunction

  task automatic add_step(input logic [1:0] op, input video_map_pkg::mpu_addr_t addr,
                          input video_map_pkg::mpu_data_t data, input logic [1:0] be,
                          input video_map_pkg::mpu_data_t vdin);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.be   = be;
    s.vdin = vdin;
    table_q.push_back(s);
  endtask

  // Expectations use the register state before this step's write
  task automatic apply_step(input step_t s);
    video_map_pkg::int_addr_t ia;
    video_map_pkg::int_addr_t vrel;
    logic                     sel;
    ia   = bank_addr(s.addr);
    vrel = ia - video_map_pkg::VRAM_BASE;
    sel  = (s.op != OP_IDLE) && in_window(ia) && vram_open();
    exp_rdata = (s.op == OP_RD) ? expected_read(ia, s.vdin) : 16'h0000;
    exp_en    = sel;
    exp_rd    = sel && (s.op == OP_RD);
    exp_wr    = sel && (s.op == OP_WR);
    exp_be    = sel ? s.be : 2'b00;
    exp_addr  = sel ? vrel[15:0] : 16'h0000;
    exp_vdata = (sel && (s.op == OP_WR)) ? s.data : 16'h0000;
    if (s.op == OP_WR) begin
      model_write(ia, s.data, s.be);
    end
    mpu_en       = s.op != OP_IDLE;
    mpu_rd       = s.op == OP_RD;
    mpu_wr       = s.op == OP_WR;
    mpu_addr     = s.addr;
    mpu_data_in  = s.data;
    mpu_be       = s.be;
    vram_data_in = s.vdin;
  endtask

  task automatic build_table();
    logic [31:0]              r;
    video_map_pkg::mpu_addr_t a;
    // Reset contents, tile holes included
    for (int i = 0; i < NUM_MAIN_REGS; i++) begin
      add_step(OP_RD, 16'(i), 16'h0000, 2'b11, 16'h0000);
    end
    for (int i = 0; i < NUM_TILE_LAYERS * 16; i++) begin
      add_step(OP_RD, 16'h0800 + 16'(i), 16'h0000, 2'b11, 16'h0000);
    end
    // Byte lanes of a main register, then a write to ID
    add_step(OP_WR, 16'h0003, 16'h1234, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0003, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_WR, 16'h0003, 16'hABCD, 2'b01, 16'h0000);
    add_step(OP_RD, 16'h0003, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_WR, 16'h0003, 16'h5600, 2'b10, 16'h0000);
    add_step(OP_RD, 16'h0003, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_WR, 16'h0000, 16'hFFFF, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0000, 16'h0000, 2'b11, 16'h0000);
    // Separate layers and a write into a hole
    add_step(OP_WR, 16'h0800, 16'h1111, 2'b11, 16'h0000);
    add_step(OP_WR, 16'h0812, 16'h2222, 2'b11, 16'h0000);
    add_step(OP_WR, 16'h0837, 16'h3333, 2'b10, 16'h0000);
    add_step(OP_WR, 16'h0809, 16'h7777, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0800, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0812, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0822, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0837, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0809, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0900, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_IDLE, 16'h0000, 16'h0000, 2'b00, 16'h0000);
    // Banking of the upper half
    add_step(OP_RD, 16'h8003, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_WR, 16'h0002, 16'h0001, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h8003, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h0003, 16'h0000, 2'b11, 16'h0000);
    // Video RAM window, closed and then open
    add_step(OP_WR, 16'h0002, 16'h0002, 2'b01, 16'h0000);
    add_step(OP_WR, 16'h8010, 16'hBEEF, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h8010, 16'h0000, 2'b11, 16'h4321);
    add_step(OP_WR, 16'h0001, 16'h0001, 2'b01, 16'h0000);
    add_step(OP_WR, 16'h8010, 16'hBEEF, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h8020, 16'h0000, 2'b11, 16'h4321);
    add_step(OP_WR, 16'h8011, 16'h00A5, 2'b01, 16'h0000);
    add_step(OP_WR, 16'h0002, 16'h0003, 2'b01, 16'h0000);
    add_step(OP_RD, 16'h8005, 16'h0000, 2'b11, 16'h9876);
    add_step(OP_RD, 16'h0002, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_WR, 16'h0001, 16'h0000, 2'b11, 16'h0000);
    add_step(OP_RD, 16'h8005, 16'h0000, 2'b11, 16'h5555);
    add_step(OP_WR, 16'h8006, 16'h1357, 2'b11, 16'h0000);
    add_step(OP_IDLE, 16'h0000, 16'h0000, 2'b00, 16'h0000);
    // Random write and read-back pairs in page 0
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = $random(seed);
      a = r[0] ? {13'h0000, r[10:8]} : 16'h0800 + {10'h000, r[13:8]};
      add_step(OP_WR, a, r[31:16], r[3:2], 16'h0000);
      add_step(OP_RD, a, 16'h0000, 2'b11, r[31:16] ^ 16'h5A5A);
    end
  endtask

  initial begin
    int limit;
    wait (table_ready);
    limit = (table_q.size() + RESET_CYCLES + 20) * CLK_PERIOD;
    #(limit);
    $display("Timeout: the stimulus table did not complete in time");
    stop_run();
  end

  initial begin
    rst          = 1'b1;
    mpu_en       = 1'b0;
    mpu_rd       = 1'b0;
    mpu_wr       = 1'b0;
    mpu_be       = 2'b00;
    mpu_addr     = 16'h0000;
    mpu_data_in  = 16'h0000;
    vram_data_in = 16'h0000;
    for (int i = 0; i < NUM_MAIN_REGS; i++) begin
      main_m[i] = 16'h0000;
    end
    for (int k = 0; k < NUM_TILE_LAYERS; k++) begin
      for (int i = 0; i < NUM_TILE_REGS; i++) begin
        tile_m[k][i] = 16'h0000;
      end
    end
    apply_step('0);
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < table_q.size(); i++) begin
      @(negedge clk);
      check_outputs();
      cur_step = i;
      apply_step(table_q[i]);
    end
    @(negedge clk);
    check_outputs();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video register testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f video_regs.f \
  --top-module video_regs_tb -Mdir obj_dir -o video_regs_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/video_regs_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Testbench reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation run completed"
exit 0

// ==== source/bank_decoder.sv ====
`timescale 1ns/1ps

module bank_decoder #(
  parameter int NUM_MAIN_REGS   = 8,
  parameter int NUM_TILE_LAYERS = 4,
  parameter int NUM_TILE_REGS   = 8
) (
  input  video_map_pkg::mpu_addr_t   mpu_addr,
  input  logic                       mpu_en,
  input  logic                       mpu_rd,
  input  logic                       mpu_wr,
  input  video_regs_pkg::bank_t      bank_value,
  input  logic                       vram_access,
  output logic                       main_wr,
  output logic                       main_sel,
  output logic                       vram_sel,
  output logic                       low_sel,
  output logic [NUM_TILE_LAYERS-1:0] tile_wr,
  output logic [NUM_TILE_LAYERS-1:0] tile_sel,
  output logic [2:0]                 reg_offset,
  output video_map_pkg::vram_addr_t  vram_offset
);

  localparam int TILE_OFS_BITS = $clog2(video_map_pkg::TILE_REG_STEP);

  logic [video_map_pkg::PAGE_OFFSET_WIDTH-1:0] page_offset;
  logic                      page_index;
  video_regs_pkg::bank_t     bank_part;
  video_map_pkg::int_addr_t  int_addr;
  video_map_pkg::int_addr_t  main_rel;
  video_map_pkg::int_addr_t  tile_rel;
  video_map_pkg::int_addr_t  tile_layer;
  video_map_pkg::int_addr_t  vram_rel;
  logic [TILE_OFS_BITS-1:0]  tile_reg;
  logic                      tile_region;
  logic                      access;

  // Page 0 is fixed, page 1 is relocated by the bank register
  assign page_offset = mpu_addr[video_map_pkg::PAGE_OFFSET_WIDTH-1:0];
  assign page_index  = mpu_addr[video_map_pkg::PAGE_OFFSET_WIDTH];
  assign bank_part   = page_index ? bank_value : '0;
  assign int_addr    = {bank_part, page_offset};

  assign access = mpu_en & (mpu_rd | mpu_wr);

  // Offsets relative to each base, addresses below a base wrap to large values
  assign main_rel = int_addr - video_map_pkg::MAIN_REG_BASE;
  assign tile_rel = int_addr - video_map_pkg::TILE_REG_BASE;
  assign vram_rel = int_addr - video_map_pkg::VRAM_BASE;

  assign main_sel = main_rel < NUM_MAIN_REGS;
  assign main_wr  = main_sel & mpu_en & mpu_wr;

  assign tile_region = tile_rel < video_map_pkg::TILE_REG_STEP * NUM_TILE_LAYERS;
  assign tile_layer  = tile_rel >> TILE_OFS_BITS;
  assign tile_reg    = tile_rel[TILE_OFS_BITS-1:0];

  // Holes past the last register in a block select no layer
  always_comb begin
    for (int k = 0; k < NUM_TILE_LAYERS; k++) begin
      tile_sel[k] = tile_region && (tile_layer == video_map_pkg::int_addr_t'(k)) &&
                    (tile_reg < NUM_TILE_REGS);
      tile_wr[k]  = tile_sel[k] & mpu_en & mpu_wr;
    end
  end

  // Register bases are aligned, so the low bits index both files
  assign reg_offset = int_addr[2:0];

  // Window is only open while the processor owns video RAM
  assign vram_sel    = (vram_rel < video_map_pkg::VRAM_LENGTH) & vram_access & access;
  assign vram_offset = video_map_pkg::vram_addr_t'(vram_rel);

  assign low_sel = int_addr < video_map_pkg::LOW_MEM_SIZE;

endmodule

// ==== source/main_registers.sv ====
`timescale 1ns/1ps

module main_registers #(
  parameter int NUM_MAIN_REGS = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      main_wr,
  input  logic [1:0]                mpu_be,
  input  logic [2:0]                reg_offset,
  input  video_map_pkg::mpu_data_t  mpu_data_in,
  output video_regs_pkg::reg_data_t main_data,
  output video_regs_pkg::bank_t     bank_value,
  output logic                      vram_access
);

  video_regs_pkg::reg_data_t regs [NUM_MAIN_REGS];
  logic                      id_hit;

  assign id_hit = reg_offset == video_regs_pkg::REG_ID;

  always_ff @(posedge clk) begin
    if (rst) begin
      // ID slot loads its fixed value and is never written afterwards
      for (int i = 0; i < NUM_MAIN_REGS; i++) begin
        regs[i] <= (i == video_regs_pkg::REG_ID) ? video_regs_pkg::ID_VALUE : '0;
      end
    end else if (main_wr && !id_hit) begin
      // Byte lanes are written independently
      if (mpu_be[0]) begin
        regs[reg_offset][7:0] <= mpu_data_in[7:0];
      end
      if (mpu_be[1]) begin
        regs[reg_offset][15:8] <= mpu_data_in[15:8];
      end
    end
  end

  assign main_data = regs[reg_offset];

  // Values the decoder needs for banking and the video RAM window
  assign bank_value  = video_regs_pkg::bank_t'(regs[video_regs_pkg::REG_MEM_BANK]);
  assign vram_access =
      regs[video_regs_pkg::REG_SYS_CTRL][video_regs_pkg::SYS_CTRL_VRAM_ACCESS];

endmodule

// ==== source/read_data_mux.sv ====
`timescale 1ns/1ps

module read_data_mux #(
  parameter int NUM_TILE_LAYERS = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       mpu_en,
  input  logic                       mpu_rd,
  input  logic                       main_sel,
  input  logic                       vram_sel,
  input  logic                       low_sel,
  input  logic [NUM_TILE_LAYERS-1:0] tile_sel,
  input  video_regs_pkg::reg_data_t  main_data,
  input  video_regs_pkg::reg_data_t  tile_data [NUM_TILE_LAYERS],
  input  video_map_pkg::mpu_data_t   vram_data_in,
  output video_map_pkg::mpu_data_t   mpu_data_out
);

  video_regs_pkg::reg_data_t tile_or;
  logic                      tile_hit;
  video_map_pkg::mpu_data_t  low_data;
  video_map_pkg::mpu_data_t  high_data;

  // tile_sel is one-hot, so an OR of the gated layers is enough
  always_comb begin
    tile_or = '0;
    for (int k = 0; k < NUM_TILE_LAYERS; k++) begin
      if (tile_sel[k]) begin
        tile_or = tile_or | tile_data[k];
      end
    end
  end

  assign tile_hit = |tile_sel;

  // Two short paths instead of one long chain
  assign low_data = main_sel ? main_data :
                    tile_hit ? tile_or : video_map_pkg::UNMAPPED_VALUE;
  assign high_data = vram_sel ? vram_data_in : video_map_pkg::UNMAPPED_VALUE;

  always_ff @(posedge clk) begin
    if (rst) begin
      mpu_data_out <= '0;
    end else if (mpu_en && mpu_rd) begin
      mpu_data_out <= low_sel ? low_data : high_data;
    end else begin
      mpu_data_out <= '0;
    end
  end

endmodule

// ==== source/tile_layer_regs.sv ====
`timescale 1ns/1ps

module tile_layer_regs #(
  parameter int NUM_TILE_REGS = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wr,
  input  logic [1:0]                mpu_be,
  input  logic [2:0]                reg_offset,
  input  video_map_pkg::mpu_data_t  mpu_data_in,
  output video_regs_pkg::reg_data_t rd_data
);

  video_regs_pkg::reg_data_t regs [NUM_TILE_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_TILE_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr) begin
      if (mpu_be[0]) begin
        regs[reg_offset][7:0] <= mpu_data_in[7:0];
      end
      if (mpu_be[1]) begin
        regs[reg_offset][15:8] <= mpu_data_in[15:8];
      end
    end
  end

  // Offset is only in range when the decoder selected this layer
  assign rd_data = regs[reg_offset];

endmodule

// ==== source/video_map_pkg.sv ====
package video_map_pkg;

  // Processor side bus widths
  typedef logic [15:0] mpu_addr_t;
  typedef logic [15:0] mpu_data_t;

  // Address after banking: 8 bank bits above a 15 bit page offset
  typedef logic [22:0] int_addr_t;

  // Word address on the external video RAM
  typedef logic [15:0] vram_addr_t;

  localparam int PAGE_OFFSET_WIDTH = 15;

  // Main control registers
  localparam int_addr_t MAIN_REG_BASE = 23'h00_0000;

  // Tile layer register blocks, one block per layer
  localparam int_addr_t TILE_REG_BASE = 23'h00_0800;
  localparam int_addr_t TILE_REG_STEP = 23'h00_0010;

  // Window onto external video RAM
  localparam int_addr_t VRAM_BASE   = 23'h01_0000;
  localparam int_addr_t VRAM_LENGTH = 23'h01_0000;

  // Split between the low and high read-back paths
  localparam int_addr_t LOW_MEM_SIZE = 23'h00_1000;

  // Returned for reads that hit nothing
  localparam mpu_data_t UNMAPPED_VALUE = 16'hDEAD;

endpackage

// ==== source/video_regs_pkg.sv ====
package video_regs_pkg;

  typedef logic [15:0] reg_data_t;

  // Upper internal address bits for page 1
  typedef logic [7:0] bank_t;

  // Main register indices
  localparam int REG_ID       = 0;
  localparam int REG_SYS_CTRL = 1;
  localparam int REG_MEM_BANK = 2;

  // System control bits
  localparam int SYS_CTRL_VRAM_ACCESS = 0;

  // Fixed contents of the read-only ID register
  localparam reg_data_t ID_VALUE = 16'hC0BE;

endpackage

// ==== source/video_regs_top.sv ====
`timescale 1ns/1ps

module video_regs_top #(
  parameter int NUM_MAIN_REGS   = 8,
  parameter int NUM_TILE_LAYERS = 4,
  parameter int NUM_TILE_REGS   = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mpu_en,
  input  logic                      mpu_rd,
  input  logic                      mpu_wr,
  input  logic [1:0]                mpu_be,
  input  video_map_pkg::mpu_addr_t  mpu_addr,
  input  video_map_pkg::mpu_data_t  mpu_data_in,
  input  video_map_pkg::mpu_data_t  vram_data_in,
  output video_map_pkg::mpu_data_t  mpu_data_out,
  output logic                      vram_en,
  output logic                      vram_rd,
  output logic                      vram_wr,
  output logic [1:0]                vram_be,
  output video_map_pkg::vram_addr_t vram_addr,
  output video_map_pkg::mpu_data_t  vram_data_out
);

  logic                       main_wr;
  logic                       main_sel;
  logic                       vram_sel;
  logic                       low_sel;
  logic [NUM_TILE_LAYERS-1:0] tile_wr;
  logic [NUM_TILE_LAYERS-1:0] tile_sel;
  logic [2:0]                 reg_offset;
  video_map_pkg::vram_addr_t  vram_offset;
  video_regs_pkg::bank_t      bank_value;
  logic                       vram_access;
  video_regs_pkg::reg_data_t  main_data;
  video_regs_pkg::reg_data_t  tile_data [NUM_TILE_LAYERS];

  bank_decoder #(
    .NUM_MAIN_REGS   (NUM_MAIN_REGS),
    .NUM_TILE_LAYERS (NUM_TILE_LAYERS),
    .NUM_TILE_REGS   (NUM_TILE_REGS)
  ) decoder_i (
    .mpu_addr    (mpu_addr),
    .mpu_en      (mpu_en),
    .mpu_rd      (mpu_rd),
    .mpu_wr      (mpu_wr),
    .bank_value  (bank_value),
    .vram_access (vram_access),
    .main_wr     (main_wr),
    .main_sel    (main_sel),
    .vram_sel    (vram_sel),
    .low_sel     (low_sel),
    .tile_wr     (tile_wr),
    .tile_sel    (tile_sel),
    .reg_offset  (reg_offset),
    .vram_offset (vram_offset)
  );

  main_registers #(
    .NUM_MAIN_REGS (NUM_MAIN_REGS)
  ) main_regs_i (
    .clk         (clk),
    .rst         (rst),
    .main_wr     (main_wr),
    .mpu_be      (mpu_be),
    .reg_offset  (reg_offset),
    .mpu_data_in (mpu_data_in),
    .main_data   (main_data),
    .bank_value  (bank_value),
    .vram_access (vram_access)
  );

  // One register block per tile layer
  for (genvar k = 0; k < NUM_TILE_LAYERS; k++) begin : tile_layer_gen
    tile_layer_regs #(
      .NUM_TILE_REGS (NUM_TILE_REGS)
    ) tile_layer_i (
      .clk         (clk),
      .rst         (rst),
      .wr          (tile_wr[k]),
      .mpu_be      (mpu_be),
      .reg_offset  (reg_offset),
      .mpu_data_in (mpu_data_in),
      .rd_data     (tile_data[k])
    );
  end

  read_data_mux #(
    .NUM_TILE_LAYERS (NUM_TILE_LAYERS)
  ) read_mux_i (
    .clk          (clk),
    .rst          (rst),
    .mpu_en       (mpu_en),
    .mpu_rd       (mpu_rd),
    .main_sel     (main_sel),
    .vram_sel     (vram_sel),
    .low_sel      (low_sel),
    .tile_sel     (tile_sel),
    .main_data    (main_data),
    .tile_data    (tile_data),
    .vram_data_in (vram_data_in),
    .mpu_data_out (mpu_data_out)
  );

  vram_port vram_port_i (
    .clk           (clk),
    .rst           (rst),
    .vram_sel      (vram_sel),
    .mpu_rd        (mpu_rd),
    .mpu_wr        (mpu_wr),
    .mpu_be        (mpu_be),
    .vram_offset   (vram_offset),
    .mpu_data_in   (mpu_data_in),
    .vram_en       (vram_en),
    .vram_rd       (vram_rd),
    .vram_wr       (vram_wr),
    .vram_be       (vram_be),
    .vram_addr     (vram_addr),
    .vram_data_out (vram_data_out)
  );

endmodule

// ==== source/vram_port.sv ====
`timescale 1ns/1ps

module vram_port (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      vram_sel,
  input  logic                      mpu_rd,
  input  logic                      mpu_wr,
  input  logic [1:0]                mpu_be,
  input  video_map_pkg::vram_addr_t vram_offset,
  input  video_map_pkg::mpu_data_t  mpu_data_in,
  output logic                      vram_en,
  output logic                      vram_rd,
  output logic                      vram_wr,
  output logic [1:0]                vram_be,
  output video_map_pkg::vram_addr_t vram_addr,
  output video_map_pkg::mpu_data_t  vram_data_out
);

  // Strobes, a read wins if both are requested
  always_ff @(posedge clk) begin
    if (rst) begin
      vram_en <= 1'b0;
      vram_rd <= 1'b0;
      vram_wr <= 1'b0;
    end else begin
      vram_en <= vram_sel;
      vram_rd <= vram_sel & mpu_rd;
      vram_wr <= vram_sel & mpu_wr & ~mpu_rd;
    end
  end

  // Payload is zero outside an access
  always_ff @(posedge clk) begin
    vram_be       <= vram_sel ? mpu_be : 2'b00;
    vram_addr     <= vram_sel ? vram_offset : '0;
    vram_data_out <= (vram_sel && mpu_wr && !mpu_rd) ? mpu_data_in : '0;
  end

endmodule

// ==== video_regs.f ====
source/video_map_pkg.sv
source/video_regs_pkg.sv
source/bank_decoder.sv
source/main_registers.sv
source/tile_layer_regs.sv
source/read_data_mux.sv
source/vram_port.sv
source/video_regs_top.sv
bench/video_regs_assert.sv
bench/video_regs_tb.sv
